//--- src/excp_pkg.sv
package excp_pkg;

    // Widths.
    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 14;
    localparam int CAUSE_W    = 5;
    localparam int EXCP_SLOTS = 6;
    localparam int ECODE_W    = 6;
    localparam int ESUBCODE_W = 9;
    localparam int INT_W      = 12;
    localparam int PAUSE_W    = 7;

    // Exception CSR addresses.
    localparam logic [CSR_ADDR_W-1:0] CSR_CRMD   = 14'h0;
    localparam logic [CSR_ADDR_W-1:0] CSR_PRMD   = 14'h1;
    localparam logic [CSR_ADDR_W-1:0] CSR_ECFG   = 14'h4;
    localparam logic [CSR_ADDR_W-1:0] CSR_ESTAT  = 14'h5;
    localparam logic [CSR_ADDR_W-1:0] CSR_ERA    = 14'h6;
    localparam logic [CSR_ADDR_W-1:0] CSR_EENTRY = 14'hc;

    // Cause codes carried by the pipeline slots.
    localparam logic [CAUSE_W-1:0] EXCEPTION_NOP  = 5'd0;
    localparam logic [CAUSE_W-1:0] EXCEPTION_INT  = 5'd1;
    localparam logic [CAUSE_W-1:0] EXCEPTION_PIL  = 5'd2;
    localparam logic [CAUSE_W-1:0] EXCEPTION_PIS  = 5'd3;
    localparam logic [CAUSE_W-1:0] EXCEPTION_PIF  = 5'd4;
    localparam logic [CAUSE_W-1:0] EXCEPTION_PME  = 5'd5;
    localparam logic [CAUSE_W-1:0] EXCEPTION_PPI  = 5'd6;
    localparam logic [CAUSE_W-1:0] EXCEPTION_ADEF = 5'd7;
    localparam logic [CAUSE_W-1:0] EXCEPTION_ADEM = 5'd8;
    localparam logic [CAUSE_W-1:0] EXCEPTION_ALE  = 5'd9;
    localparam logic [CAUSE_W-1:0] EXCEPTION_SYS  = 5'd10;
    localparam logic [CAUSE_W-1:0] EXCEPTION_BRK  = 5'd11;
    localparam logic [CAUSE_W-1:0] EXCEPTION_INE  = 5'd12;
    localparam logic [CAUSE_W-1:0] EXCEPTION_IPE  = 5'd13;
    localparam logic [CAUSE_W-1:0] EXCEPTION_FPD  = 5'd14;
    localparam logic [CAUSE_W-1:0] EXCEPTION_FPE  = 5'd15;

    // Architectural ecodes written to ESTAT.
    localparam logic [ECODE_W-1:0] ECODE_INT = 6'h0;
    localparam logic [ECODE_W-1:0] ECODE_PIL = 6'h1;
    localparam logic [ECODE_W-1:0] ECODE_PIS = 6'h2;
    localparam logic [ECODE_W-1:0] ECODE_PIF = 6'h3;
    localparam logic [ECODE_W-1:0] ECODE_PME = 6'h4;
    localparam logic [ECODE_W-1:0] ECODE_PPI = 6'h7;
    localparam logic [ECODE_W-1:0] ECODE_ADE = 6'h8;
    localparam logic [ECODE_W-1:0] ECODE_ALE = 6'h9;
    localparam logic [ECODE_W-1:0] ECODE_SYS = 6'hb;
    localparam logic [ECODE_W-1:0] ECODE_BRK = 6'hc;
    localparam logic [ECODE_W-1:0] ECODE_INE = 6'hd;
    localparam logic [ECODE_W-1:0] ECODE_IPE = 6'he;
    localparam logic [ECODE_W-1:0] ECODE_FPD = 6'hf;
    localparam logic [ECODE_W-1:0] ECODE_FPE = 6'h12;

    // Pause bits: 0 pc, 1 icache, 2 inst buffer, 3 id, 4 dispatch, 5 ex, 6 mem.
    localparam logic [PAUSE_W-1:0] PAUSE_IF       = 7'b0000001;
    localparam logic [PAUSE_W-1:0] PAUSE_ID       = 7'b0001111;
    localparam logic [PAUSE_W-1:0] PAUSE_DISPATCH = 7'b0011111;
    localparam logic [PAUSE_W-1:0] PAUSE_EX       = 7'b0111111;
    localparam logic [PAUSE_W-1:0] PAUSE_MEM      = 7'b1111111;

    // One CSR write word, seen as CRMD or as an interrupt-line word.
    typedef union packed {
        struct packed {
            logic [28:0] rsvd_31_3;
            logic        ie;
            logic [1:0]  rsvd_1_0;
        } crmd;
        struct packed {
            logic [18:0] rsvd_31_13;
            logic [1:0]  line_hi;
            logic        rsvd_10;
            logic [9:0]  line_lo;
        } intr;
    } csr_word_u;

endpackage

//--- src/excp_cause_decode.sv
module excp_cause_decode (
    input  logic [excp_pkg::EXCP_SLOTS-1:0]              excp_vec_i,
    input  logic [excp_pkg::EXCP_SLOTS*excp_pkg::CAUSE_W-1:0] excp_cause_i,
    output logic                                         excp_taken_o,
    output logic [excp_pkg::CAUSE_W-1:0]                 cause_o,
    output logic [excp_pkg::ECODE_W-1:0]                 ecode_o,
    output logic [excp_pkg::ESUBCODE_W-1:0]              esubcode_o
);

    // Higher slots overwrite lower ones, so slot 5 wins.
    always_comb begin
        excp_taken_o = 1'b0;
        cause_o      = excp_pkg::EXCEPTION_NOP;
        for (int k = 0; k < excp_pkg::EXCP_SLOTS; k++) begin
            if (excp_vec_i[k]) begin
                excp_taken_o = 1'b1;
                cause_o      = excp_cause_i[k*excp_pkg::CAUSE_W +: excp_pkg::CAUSE_W];
            end
        end
        // An active slot must carry a real cause
        assert final (!excp_taken_o || cause_o != excp_pkg::EXCEPTION_NOP)
            else $error("active exception slot with NOP cause");
    end

    always_comb begin
        esubcode_o = '0;
        case (cause_o)
            excp_pkg::EXCEPTION_INT: begin
                ecode_o = excp_pkg::ECODE_INT;
            end
            excp_pkg::EXCEPTION_PIL: begin
                ecode_o = excp_pkg::ECODE_PIL;
            end
            excp_pkg::EXCEPTION_PIS: begin
                ecode_o = excp_pkg::ECODE_PIS;
            end
            excp_pkg::EXCEPTION_PIF: begin
                ecode_o = excp_pkg::ECODE_PIF;
            end
            excp_pkg::EXCEPTION_PME: begin
                ecode_o = excp_pkg::ECODE_PME;
            end
            excp_pkg::EXCEPTION_PPI: begin
                ecode_o = excp_pkg::ECODE_PPI;
            end
            excp_pkg::EXCEPTION_ADEF: begin
                ecode_o = excp_pkg::ECODE_ADE;
            end
            excp_pkg::EXCEPTION_ADEM: begin
                // Same ecode as ADEF, told apart by esubcode.
                ecode_o    = excp_pkg::ECODE_ADE;
                esubcode_o = 9'd1;
            end
            excp_pkg::EXCEPTION_ALE: begin
                ecode_o = excp_pkg::ECODE_ALE;
            end
            excp_pkg::EXCEPTION_SYS: begin
                ecode_o = excp_pkg::ECODE_SYS;
            end
            excp_pkg::EXCEPTION_BRK: begin
                ecode_o = excp_pkg::ECODE_BRK;
            end
            excp_pkg::EXCEPTION_INE: begin
                ecode_o = excp_pkg::ECODE_INE;
            end
            excp_pkg::EXCEPTION_IPE: begin
                ecode_o = excp_pkg::ECODE_IPE;
            end
            excp_pkg::EXCEPTION_FPD: begin
                ecode_o = excp_pkg::ECODE_FPD;
            end
            excp_pkg::EXCEPTION_FPE: begin
                ecode_o = excp_pkg::ECODE_FPE;
            end
            default: begin
                ecode_o = '0;
            end
        endcase
    end

endmodule

//--- src/excp_csr_regs.sv
module excp_csr_regs (
    input  logic                               clk,
    input  logic                               rst_n_i,
    input  logic                               wb_csr_we_i,
    input  logic [excp_pkg::CSR_ADDR_W-1:0]    wb_csr_waddr_i,
    input  logic [excp_pkg::XLEN-1:0]          wb_csr_wdata_i,
    input  logic                               excp_taken_i,
    input  logic [excp_pkg::ECODE_W-1:0]       ecode_i,
    input  logic [excp_pkg::ESUBCODE_W-1:0]    esubcode_i,
    input  logic                               is_ertn_i,
    input  logic [excp_pkg::XLEN-1:0]          pc_i,
    input  logic [excp_pkg::CSR_ADDR_W-1:0]    csr_raddr_i,
    output logic [excp_pkg::XLEN-1:0]          csr_rdata_o,
    output logic [excp_pkg::XLEN-1:0]          era_cur_o,
    output logic [excp_pkg::XLEN-1:0]          eentry_cur_o,
    output logic                               int_pending_o
);

    logic                            crmd_ie_q;
    logic                            prmd_pie_q;
    logic [excp_pkg::INT_W-1:0]      ecfg_lie_q;
    logic [excp_pkg::INT_W-1:0]      estat_is_q;
    logic [excp_pkg::ECODE_W-1:0]    estat_ecode_q;
    logic [excp_pkg::ESUBCODE_W-1:0] estat_esubcode_q;
    logic [excp_pkg::XLEN-1:0]       era_q;
    logic [excp_pkg::XLEN-1:0]       eentry_q;

    excp_pkg::csr_word_u             wword;
    logic [excp_pkg::INT_W-1:0]      wlines;
    logic                            we_crmd, we_prmd, we_ecfg, we_estat, we_era, we_eentry;
    logic                            ie_cur, pie_cur;
    logic [excp_pkg::INT_W-1:0]      lie_cur, is_cur;

    assign wword  = wb_csr_wdata_i;
    assign wlines = {wword.intr.line_hi, wword.intr.line_lo};

    assign we_crmd   = wb_csr_we_i && (wb_csr_waddr_i == excp_pkg::CSR_CRMD);
    assign we_prmd   = wb_csr_we_i && (wb_csr_waddr_i == excp_pkg::CSR_PRMD);
    assign we_ecfg   = wb_csr_we_i && (wb_csr_waddr_i == excp_pkg::CSR_ECFG);
    assign we_estat  = wb_csr_we_i && (wb_csr_waddr_i == excp_pkg::CSR_ESTAT);
    assign we_era    = wb_csr_we_i && (wb_csr_waddr_i == excp_pkg::CSR_ERA);
    assign we_eentry = wb_csr_we_i && (wb_csr_waddr_i == excp_pkg::CSR_EENTRY);

    // Writeback values seen by redirect and interrupt logic this cycle.
    assign ie_cur       = we_crmd ? wword.crmd.ie : crmd_ie_q;
    assign pie_cur      = we_prmd ? wword.crmd.ie : prmd_pie_q;
    assign lie_cur      = we_ecfg ? wlines : ecfg_lie_q;
    assign is_cur       = we_estat ? wlines : estat_is_q;
    assign era_cur_o    = we_era ? wb_csr_wdata_i : era_q;
    assign eentry_cur_o = we_eentry ? wb_csr_wdata_i : eentry_q;

    assign int_pending_o = ie_cur && ((lie_cur & is_cur) != '0);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            crmd_ie_q        <= 1'b0;
            prmd_pie_q       <= 1'b0;
            ecfg_lie_q       <= '0;
            estat_is_q       <= '0;
            estat_ecode_q    <= '0;
            estat_esubcode_q <= '0;
            era_q            <= '0;
            eentry_q         <= '0;
        end else begin
            // Commit wins over a software write to the same field.
            if (excp_taken_i) begin
                crmd_ie_q        <= 1'b0;
                prmd_pie_q       <= ie_cur;
                era_q            <= pc_i;
                estat_ecode_q    <= ecode_i;
                estat_esubcode_q <= esubcode_i;
            end else begin
                if (is_ertn_i) begin
                    crmd_ie_q <= pie_cur;
                end else if (we_crmd) begin
                    crmd_ie_q <= wword.crmd.ie;
                end
                if (we_prmd) begin
                    prmd_pie_q <= wword.crmd.ie;
                end
                if (we_era) begin
                    era_q <= wb_csr_wdata_i;
                end
            end
            if (we_ecfg) begin
                ecfg_lie_q <= wlines;
            end
            if (we_estat) begin
                estat_is_q <= wlines;
            end
            if (we_eentry) begin
                eentry_q <= wb_csr_wdata_i;
            end
        end
    end

    always_comb begin
        case (csr_raddr_i)
            excp_pkg::CSR_CRMD:   csr_rdata_o = {29'b0, crmd_ie_q, 2'b0};
            excp_pkg::CSR_PRMD:   csr_rdata_o = {29'b0, prmd_pie_q, 2'b0};
            excp_pkg::CSR_ECFG:   csr_rdata_o = {19'b0, ecfg_lie_q[11:10], 1'b0, ecfg_lie_q[9:0]};
            excp_pkg::CSR_ESTAT:  csr_rdata_o = {1'b0, estat_esubcode_q, estat_ecode_q, 3'b0,
                                                 estat_is_q[11:10], 1'b0, estat_is_q[9:0]};
            excp_pkg::CSR_ERA:    csr_rdata_o = era_q;
            excp_pkg::CSR_EENTRY: csr_rdata_o = eentry_q;
            default:              csr_rdata_o = '0;
        endcase
    end

    assert property (@(posedge clk) disable iff (!rst_n_i) !(excp_taken_i && is_ertn_i))
        else $error("exception and ertn committed in the same cycle");

endmodule

//--- src/pipe_ctrl.sv
module pipe_ctrl (
    input  logic                           excp_taken_i,
    input  logic                           is_ertn_i,
    input  logic                           is_idle_i,
    input  logic                           continue_idle_i,
    input  logic [excp_pkg::XLEN-1:0]      era_cur_i,
    input  logic [excp_pkg::XLEN-1:0]      eentry_cur_i,
    input  logic                           int_pending_i,
    input  logic                           pause_if_i,
    input  logic                           pause_id_i,
    input  logic                           pause_dispatch_i,
    input  logic                           pause_ex_i,
    input  logic                           pause_mem_i,
    output logic                           flush_o,
    output logic [excp_pkg::XLEN-1:0]      new_pc_o,
    output logic                           is_interrupt_o,
    output logic [excp_pkg::PAUSE_W-1:0]   pause_o,
    output logic                           send_inst1_en_o
);

    logic pause_idle;

    // Redirect on both exception entry and return.
    assign flush_o  = excp_taken_i || is_ertn_i;
    assign new_pc_o = is_ertn_i ? era_cur_i : eentry_cur_i;

    assign is_interrupt_o = int_pending_i;

    // Idle holds the whole pipe until an interrupt or an explicit release.
    assign pause_idle = is_idle_i && !int_pending_i && !continue_idle_i;

    always_comb begin
        if (pause_if_i) begin
            pause_o = excp_pkg::PAUSE_IF;
        end else if (pause_id_i) begin
            pause_o = excp_pkg::PAUSE_ID;
        end else if (pause_dispatch_i) begin
            pause_o = excp_pkg::PAUSE_DISPATCH;
        end else if (pause_ex_i) begin
            pause_o = excp_pkg::PAUSE_EX;
        end else if (pause_mem_i || pause_idle) begin
            pause_o = excp_pkg::PAUSE_MEM;
        end else begin
            pause_o = '0;
        end
    end

    // The second issue slot stalls with the inst buffer.
    assign send_inst1_en_o = !pause_o[2];

    always_comb begin
        assert final (!(is_ertn_i && excp_taken_i))
            else $error("redirect requested for exception and ertn together");
    end

endmodule

//--- src/excp_ctrl_top.sv
module excp_ctrl_top (
    input  logic                                         clk,
    input  logic                                         rst_n_i,
    input  logic [excp_pkg::XLEN-1:0]                    mem_pc_i,
    input  logic [excp_pkg::EXCP_SLOTS-1:0]              mem_excp_vec_i,
    input  logic [excp_pkg::EXCP_SLOTS*excp_pkg::CAUSE_W-1:0] mem_excp_cause_i,
    input  logic                                         mem_is_ertn_i,
    input  logic                                         mem_is_idle_i,
    input  logic                                         wb_csr_we_i,
    input  logic [excp_pkg::CSR_ADDR_W-1:0]              wb_csr_waddr_i,
    input  logic [excp_pkg::XLEN-1:0]                    wb_csr_wdata_i,
    input  logic [excp_pkg::CSR_ADDR_W-1:0]              csr_raddr_i,
    input  logic                                         pause_if_i,
    input  logic                                         pause_id_i,
    input  logic                                         pause_dispatch_i,
    input  logic                                         pause_ex_i,
    input  logic                                         pause_mem_i,
    input  logic                                         continue_idle_i,
    output logic [excp_pkg::XLEN-1:0]                    csr_rdata_o,
    output logic                                         flush_o,
    output logic [excp_pkg::XLEN-1:0]                    new_pc_o,
    output logic                                         is_interrupt_o,
    output logic [excp_pkg::PAUSE_W-1:0]                 pause_o,
    output logic                                         send_inst1_en_o
);

    logic                            excp_taken;
    logic [excp_pkg::ECODE_W-1:0]    ecode;
    logic [excp_pkg::ESUBCODE_W-1:0] esubcode;
    logic [excp_pkg::XLEN-1:0]       era_cur;
    logic [excp_pkg::XLEN-1:0]       eentry_cur;
    logic                            int_pending;

    excp_cause_decode excp_cause_decode_inst (
        .excp_vec_i   (mem_excp_vec_i),
        .excp_cause_i (mem_excp_cause_i),
        .excp_taken_o (excp_taken),
        .cause_o      (),
        .ecode_o      (ecode),
        .esubcode_o   (esubcode)
    );

    excp_csr_regs excp_csr_regs_inst (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .wb_csr_we_i    (wb_csr_we_i),
        .wb_csr_waddr_i (wb_csr_waddr_i),
        .wb_csr_wdata_i (wb_csr_wdata_i),
        .excp_taken_i   (excp_taken),
        .ecode_i        (ecode),
        .esubcode_i     (esubcode),
        .is_ertn_i      (mem_is_ertn_i),
        .pc_i           (mem_pc_i),
        .csr_raddr_i    (csr_raddr_i),
        .csr_rdata_o    (csr_rdata_o),
        .era_cur_o      (era_cur),
        .eentry_cur_o   (eentry_cur),
        .int_pending_o  (int_pending)
    );

    pipe_ctrl pipe_ctrl_inst (
        .excp_taken_i     (excp_taken),
        .is_ertn_i        (mem_is_ertn_i),
        .is_idle_i        (mem_is_idle_i),
        .continue_idle_i  (continue_idle_i),
        .era_cur_i        (era_cur),
        .eentry_cur_i     (eentry_cur),
        .int_pending_i    (int_pending),
        .pause_if_i       (pause_if_i),
        .pause_id_i       (pause_id_i),
        .pause_dispatch_i (pause_dispatch_i),
        .pause_ex_i       (pause_ex_i),
        .pause_mem_i      (pause_mem_i),
        .flush_o          (flush_o),
        .new_pc_o         (new_pc_o),
        .is_interrupt_o   (is_interrupt_o),
        .pause_o          (pause_o),
        .send_inst1_en_o  (send_inst1_en_o)
    );

endmodule

//--- tb/excp_ctrl_vectors.svh
`ifndef EXCP_CTRL_VECTORS_SVH
`define EXCP_CTRL_VECTORS_SVH

// Columns: slot vector, causes of slots 5..0, pause requests {if,id,dispatch,ex,mem},
// expected ecode, expected esubcode, expected pause_o.
localparam int NUM_ROWS = 13;

localparam logic [62:0] VECTOR_TABLE [0:NUM_ROWS-1] = '{
    {6'b000001, {5'd0, 5'd0, 5'd0, 5'd0, 5'd0, 5'd10}, 5'b00000, 6'h0b, 9'd0, 7'b0000000},
    {6'b100001, {5'd11, 5'd0, 5'd0, 5'd0, 5'd0, 5'd10}, 5'b10000, 6'h0c, 9'd0, 7'b0000001},
    {6'b000110, {5'd0, 5'd0, 5'd0, 5'd8, 5'd12, 5'd0}, 5'b01000, 6'h08, 9'd1, 7'b0001111},
    {6'b001010, {5'd0, 5'd11, 5'd7, 5'd0, 5'd9, 5'd0}, 5'b01100, 6'h08, 9'd0, 7'b0001111},
    {6'b010000, {5'd0, 5'd15, 5'd0, 5'd0, 5'd0, 5'd0}, 5'b00110, 6'h12, 9'd0, 7'b0011111},
    {6'b000011, {5'd10, 5'd0, 5'd0, 5'd0, 5'd2, 5'd1}, 5'b00011, 6'h01, 9'd0, 7'b0111111},
    {6'b100000, {5'd6, 5'd0, 5'd0, 5'd0, 5'd0, 5'd0}, 5'b00001, 6'h07, 9'd0, 7'b1111111},
    {6'b000100, {5'd0, 5'd0, 5'd0, 5'd5, 5'd0, 5'd0}, 5'b11111, 6'h04, 9'd0, 7'b0000001},
    {6'b011000, {5'd0, 5'd13, 5'd14, 5'd0, 5'd0, 5'd0}, 5'b00000, 6'h0e, 9'd0, 7'b0000000},
    {6'b000001, {5'd0, 5'd0, 5'd0, 5'd0, 5'd0, 5'd20}, 5'b00101, 6'h00, 9'd0, 7'b0011111},
    {6'b001000, {5'd0, 5'd0, 5'd3, 5'd0, 5'd0, 5'd0}, 5'b00010, 6'h02, 9'd0, 7'b0111111},
    {6'b000010, {5'd0, 5'd0, 5'd0, 5'd0, 5'd4, 5'd0}, 5'b01001, 6'h03, 9'd0, 7'b0001111},
    {6'b000010, {5'd0, 5'd0, 5'd0, 5'd0, 5'd12, 5'd0}, 5'b00000, 6'h0d, 9'd0, 7'b0000000}
};

`endif

//--- tb/excp_ctrl_tb.sv
module excp_ctrl_tb;

    `include "excp_ctrl_vectors.svh"

    localparam int NUM_RANDOM = 8;
    localparam int SEQ_STEPS  = 32;
    localparam int TIMEOUT    = (NUM_ROWS + NUM_RANDOM + SEQ_STEPS + 16) * 100 * 2;

    logic        clk = 1'b0;
    logic        rst_n_i;
    logic [31:0] mem_pc_i;
    logic [5:0]  mem_excp_vec_i;
    logic [29:0] mem_excp_cause_i;
    logic        mem_is_ertn_i;
    logic        mem_is_idle_i;
    logic        wb_csr_we_i;
    logic [13:0] wb_csr_waddr_i;
    logic [31:0] wb_csr_wdata_i;
    logic [13:0] csr_raddr_i;
    logic [4:0]  pause_req;
    logic        continue_idle_i;
    logic [31:0] csr_rdata_o;
    logic        flush_o;
    logic [31:0] new_pc_o;
    logic        is_interrupt_o;
    logic [6:0]  pause_o;
    logic        send_inst1_en_o;

    int checks   = 0;
    int errors   = 0;
    int tests    = 0;
    int failing  = 0;
    int err_mark = 0;

    excp_ctrl_top excp_ctrl_top_inst (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .mem_pc_i         (mem_pc_i),
        .mem_excp_vec_i   (mem_excp_vec_i),
        .mem_excp_cause_i (mem_excp_cause_i),
        .mem_is_ertn_i    (mem_is_ertn_i),
        .mem_is_idle_i    (mem_is_idle_i),
        .wb_csr_we_i      (wb_csr_we_i),
        .wb_csr_waddr_i   (wb_csr_waddr_i),
        .wb_csr_wdata_i   (wb_csr_wdata_i),
        .csr_raddr_i      (csr_raddr_i),
        .pause_if_i       (pause_req[4]),
        .pause_id_i       (pause_req[3]),
        .pause_dispatch_i (pause_req[2]),
        .pause_ex_i       (pause_req[1]),
        .pause_mem_i      (pause_req[0]),
        .continue_idle_i  (continue_idle_i),
        .csr_rdata_o      (csr_rdata_o),
        .flush_o          (flush_o),
        .new_pc_o         (new_pc_o),
        .is_interrupt_o   (is_interrupt_o),
        .pause_o          (pause_o),
        .send_inst1_en_o  (send_inst1_en_o)
    );

    always #50 clk = ~clk;

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR at %0t: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic zero_inputs();
        mem_pc_i         = '0;
        mem_excp_vec_i   = '0;
        mem_excp_cause_i = '0;
        mem_is_ertn_i    = 1'b0;
        mem_is_idle_i    = 1'b0;
        wb_csr_we_i      = 1'b0;
        wb_csr_waddr_i   = '0;
        wb_csr_wdata_i   = '0;
        csr_raddr_i      = '0;
        pause_req        = '0;
        continue_idle_i  = 1'b0;
    endtask

    // Inputs change on the falling edge only.
    task automatic next_cycle();
        @(negedge clk);
        zero_inputs();
    endtask

    task automatic csr_write(input logic [13:0] addr, input logic [31:0] data);
        next_cycle();
        wb_csr_we_i    = 1'b1;
        wb_csr_waddr_i = addr;
        wb_csr_wdata_i = data;
    endtask

    task automatic csr_expect(input logic [13:0] addr, input logic [31:0] mask,
                              input logic [31:0] expected, input string what);
        next_cycle();
        csr_raddr_i = addr;
        #20;
        check(csr_rdata_o & mask, expected, what);
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == err_mark) begin
            $display("%s: ok", name);
        end else begin
            failing++;
            $display("%s: mismatch (%0d errors)", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // Architectural ecode and esubcode for each cause code, as {esubcode, ecode}.
    function automatic logic [14:0] code_for_cause(input logic [4:0] cause);
        case (cause)
            5'd1:    return {9'd0, 6'h00};
            5'd2:    return {9'd0, 6'h01};
            5'd3:    return {9'd0, 6'h02};
            5'd4:    return {9'd0, 6'h03};
            5'd5:    return {9'd0, 6'h04};
            5'd6:    return {9'd0, 6'h07};
            5'd7:    return {9'd0, 6'h08};
            5'd8:    return {9'd1, 6'h08};
            5'd9:    return {9'd0, 6'h09};
            5'd10:   return {9'd0, 6'h0b};
            5'd11:   return {9'd0, 6'h0c};
            5'd12:   return {9'd0, 6'h0d};
            5'd13:   return {9'd0, 6'h0e};
            5'd14:   return {9'd0, 6'h0f};
            5'd15:   return {9'd0, 6'h12};
            default: return 15'd0;
        endcase
    endfunction

    task automatic apply_row(input logic [5:0] vec, input logic [29:0] causes,
                             input logic [4:0] req, input logic [5:0] ecode,
                             input logic [8:0] esub, input logic [6:0] pause_exp);
        next_cycle();
        mem_excp_vec_i   = vec;
        mem_excp_cause_i = causes;
        mem_pc_i         = 32'h1c00_0000;
        pause_req        = req;
        #20;
        check(32'(flush_o), 32'd1, "flush on exception");
        check(32'(pause_o), 32'(pause_exp), "pause vector");
        check(32'(send_inst1_en_o), 32'(!pause_exp[2]), "second issue enable");
        csr_expect(excp_pkg::CSR_ESTAT, 32'h7fff_0000, {1'b0, esub, ecode, 16'h0},
                   "ESTAT ecode and esubcode");
    endtask

    initial begin
        #(TIMEOUT);
        $display("timeout: the run did not finish within %0d time units", TIMEOUT);
        $display("test failed");
        $finish;
    end

    initial begin
        integer              seed;
        logic [5:0]          vec;
        logic [29:0]         causes;
        logic [4:0]          sel;
        logic [14:0]         code;
        excp_pkg::csr_word_u word;
        seed    = 32'h5d76;
        rst_n_i = 1'b0;
        zero_inputs();
        repeat (16) @(posedge clk);
        next_cycle();
        rst_n_i = 1'b1;
        #20;
        check(32'(flush_o), 32'd0, "flush after reset");
        check(32'(pause_o), 32'd0, "pause after reset");
        check(32'(is_interrupt_o), 32'd0, "interrupt after reset");
        end_test("reset");

        for (int r = 0; r < NUM_ROWS; r++) begin
            apply_row(VECTOR_TABLE[r][62:57], VECTOR_TABLE[r][56:27], VECTOR_TABLE[r][26:22],
                      VECTOR_TABLE[r][21:16], VECTOR_TABLE[r][15:7], VECTOR_TABLE[r][6:0]);
            end_test($sformatf("row %0d", r));
        end

        for (int n = 0; n < NUM_RANDOM; n++) begin
            vec = 6'($random(seed));
            if (vec == '0) begin
                vec = 6'b000001;
            end
            sel = '0;
            // The highest active slot decides the cause.
            for (int k = 0; k < 6; k++) begin
                causes[k*5 +: 5] = 5'(($random(seed) & 32'd15) + 32'd1);
                if (vec[k]) begin
                    sel = causes[k*5 +: 5];
                end
            end
            code = code_for_cause(sel);
            apply_row(vec, causes, 5'b0, code[5:0], code[14:6], 7'b0);
            end_test($sformatf("random %0d", n));
        end

        csr_write(excp_pkg::CSR_EENTRY, 32'h1c00_8000);
        csr_expect(excp_pkg::CSR_EENTRY, '1, 32'h1c00_8000, "EENTRY readback");
        csr_write(excp_pkg::CSR_ERA, 32'h1c00_0100);
        csr_expect(excp_pkg::CSR_ERA, '1, 32'h1c00_0100, "ERA readback");
        csr_write(excp_pkg::CSR_ECFG, 32'hffff_ffff);
        csr_expect(excp_pkg::CSR_ECFG, '1, 32'h0000_1bff, "ECFG line field");
        csr_write(excp_pkg::CSR_ESTAT, 32'h0000_0c03);
        csr_expect(excp_pkg::CSR_ESTAT, 32'h0000_ffff, 32'h0000_0803, "ESTAT.IS line field");
        check(32'(is_interrupt_o), 32'd0, "no interrupt while IE is clear");
        end_test("csr write and readback");

        csr_write(excp_pkg::CSR_EENTRY, 32'h1c00_a000);
        mem_excp_vec_i   = 6'b000001;
        mem_excp_cause_i = 30'd10;
        mem_pc_i         = 32'h1c00_2000;
        #20;
        check(new_pc_o, 32'h1c00_a000, "redirect to forwarded EENTRY");
        check(32'(flush_o), 32'd1, "flush on exception");
        next_cycle();
        mem_is_ertn_i = 1'b1;
        #20;
        check(new_pc_o, 32'h1c00_2000, "redirect to ERA on ertn");
        check(32'(flush_o), 32'd1, "flush on ertn");
        csr_write(excp_pkg::CSR_ERA, 32'h1c00_0040);
        mem_is_ertn_i = 1'b1;
        #20;
        check(new_pc_o, 32'h1c00_0040, "redirect to forwarded ERA");
        end_test("forwarding and redirect");

        word         = '0;
        word.crmd.ie = 1'b1;
        csr_write(excp_pkg::CSR_CRMD, word);
        #20;
        check(32'(is_interrupt_o), 32'd1, "interrupt with forwarded IE");
        csr_expect(excp_pkg::CSR_CRMD, '1, 32'h4, "CRMD.IE set");
        next_cycle();
        mem_excp_vec_i   = 6'b100000;
        mem_excp_cause_i = {5'd11, 25'd0};
        mem_pc_i         = 32'h1c00_1234;
        csr_expect(excp_pkg::CSR_ERA, '1, 32'h1c00_1234, "ERA after exception");
        csr_expect(excp_pkg::CSR_CRMD, '1, 32'h0, "CRMD.IE cleared");
        csr_expect(excp_pkg::CSR_PRMD, '1, 32'h4, "PRMD.PIE saved");
        next_cycle();
        mem_is_ertn_i = 1'b1;
        csr_expect(excp_pkg::CSR_CRMD, '1, 32'h4, "CRMD.IE restored");
        end_test("exception commit and return");

        next_cycle();
        #20;
        check(32'(is_interrupt_o), 32'd1, "interrupt pending");
        csr_write(excp_pkg::CSR_ESTAT, 32'h0);
        mem_is_idle_i = 1'b1;
        #20;
        check(32'(is_interrupt_o), 32'd0, "interrupt cleared by forwarded ESTAT");
        check(32'(pause_o), 32'h7f, "idle pause");
        check(32'(send_inst1_en_o), 32'd0, "second issue stalled in idle");
        next_cycle();
        mem_is_idle_i   = 1'b1;
        continue_idle_i = 1'b1;
        #20;
        check(32'(pause_o), 32'h0, "idle released");
        word              = '0;
        word.intr.line_lo = 10'h001;
        csr_write(excp_pkg::CSR_ESTAT, word);
        mem_is_idle_i = 1'b1;
        #20;
        check(32'(is_interrupt_o), 32'd1, "interrupt on line 0");
        check(32'(pause_o), 32'h0, "idle woken by interrupt");
        csr_write(excp_pkg::CSR_ECFG, 32'h2);
        mem_is_idle_i = 1'b1;
        #20;
        check(32'(is_interrupt_o), 32'd0, "no overlap of LIE and IS");
        check(32'(pause_o), 32'h7f, "idle pause without interrupt");
        end_test("interrupt and idle");

        $display("tests %0d, failing %0d, checks %0d, errors %0d",
                 tests, failing, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- excp_ctrl.f
+incdir+tb
src/excp_pkg.sv
src/excp_cause_decode.sv
src/excp_csr_regs.sv
src/pipe_ctrl.sv
src/excp_ctrl_top.sv
tb/excp_ctrl_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator and run; the result comes from the simulation output.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module excp_ctrl_tb -f excp_ctrl.f &&
./obj_dir/Vexcp_ctrl_tb | tee /dev/stderr | grep -qx "test passed" &&
echo "simulation ok" ||
{ echo "simulation reported failure or did not build"; exit 1; }
